// ==== hw/dmem_pkg.sv ====
// operation and cause enums, io fsm states, memory map and size constants
`default_nettype none

package dmem_pkg;

    localparam int DATA_W  = 32;                 // data path width
    localparam int BYTE_W  = 4;                  // byte enables per word
    localparam int RAM_WORDS = 4096;             // ram depth in words
    localparam int RAM_AW  = 12;                 // ram word address width
    localparam logic [31:0] IO_BASE = 32'h8000_0000;
    localparam int IO_REGS = 4;                  // scratch registers in io block

    localparam int REGION_BIT   = 31;            // set selects the io region
    localparam int OP_STORE_BIT = 3;
    localparam int OP_SIGN_BIT  = 2;

    localparam logic [1:0] SIZE_WORD = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_BYTE = 2'b11;

    // bit 3 store, bit 2 sign extend, bits 1:0 size
    typedef enum logic [3:0] {
        OP_LW  = 4'd0,
        OP_LHU = 4'd1,
        OP_LBU = 4'd3,
        OP_LH  = 4'd5,
        OP_LB  = 4'd7,
        OP_SW  = 4'd8,
        OP_SH  = 4'd9,
        OP_SB  = 4'd11
    } mem_op_e;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_DBE  = 5'd7                          // data bus error
    } exc_cause_e;

    typedef enum logic {
        IO_IDLE,                                 // first cycle of an access
        IO_WAIT                                  // completing cycle
    } io_state_e;

endpackage

`default_nettype wire

// ==== hw/store_align.sv ====
// store data alignment into big-endian byte lanes with byte enables
`timescale 1ns/1ps
`default_nettype none

module store_align
    import dmem_pkg::*;
(
    input  logic [DATA_W-1:0] write_data,    // item in the low bits
    input  logic [1:0]        offset,        // byte offset within the word
    input  logic [1:0]        size,
    output logic [BYTE_W-1:0] byteen,
    output logic [DATA_W-1:0] wdata_out
);

    logic [4:0] lane_shift;                   // bit distance of byte lane from lsb

    assign lane_shift = {~offset, 3'b000};   // offset 0 lands in lane 3

    always_comb
    begin
        case (size)
            SIZE_BYTE:
            begin
                byteen    = 4'b0001 << ~offset;
                wdata_out = {24'b0, write_data[7:0]} << lane_shift;
            end
            SIZE_HALF:
            begin
                if (offset[1])                 // lower half
                begin
                    byteen    = 4'b0011;
                    wdata_out = {16'b0, write_data[15:0]};
                end
                else                           // upper half
                begin
                    byteen    = 4'b1100;
                    wdata_out = {write_data[15:0], 16'b0};
                end
            end
            default:                           // word uses all lanes
            begin
                byteen    = 4'b1111;
                wdata_out = write_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/load_align.sv ====
// load data lane select with sign or zero extension
`timescale 1ns/1ps
`default_nettype none

module load_align
    import dmem_pkg::*;
(
    input  logic [DATA_W-1:0] rdata,         // word as returned by the bus
    input  logic [1:0]        offset,
    input  logic [1:0]        size,
    input  logic              sign_ext,
    output logic [DATA_W-1:0] load_result
);

    logic [DATA_W-1:0] shifted;               // addressed lane moved to the bottom
    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;

    // same big-endian rule as the store side
    assign shifted  = rdata >> {~offset, 3'b000};
    assign byte_sel = shifted[7:0];
    assign half_sel = offset[1] ? rdata[15:0] : rdata[31:16];

    always_comb
    begin
        case (size)
            SIZE_BYTE:
                load_result = {{24{sign_ext & byte_sel[7]}}, byte_sel};
            SIZE_HALF:
                load_result = {{16{sign_ext & half_sel[15]}}, half_sel};
            default:
                load_result = rdata;          // word needs no extension
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
// processor-side memory interface with op decode, offset latch and internal bus drive
`timescale 1ns/1ps
`default_nettype none

module data_mem
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              en,
    input  mem_op_e           op,
    input  logic [31:0]       d_address,
    input  logic [DATA_W-1:0] d_writedata,
    output logic [DATA_W-1:0] d_loadresult,
    output logic              stalled,
    output exc_cause_e        ecause,
    output logic [31:0]       bus_address,
    output logic [BYTE_W-1:0] bus_byteen,
    output logic              bus_we,
    output logic              bus_en,
    output logic [DATA_W-1:0] bus_writedata,
    input  logic [DATA_W-1:0] bus_readdata,
    input  logic              bus_wait,
    input  exc_cause_e        bus_ecause
);

    logic       is_store;
    logic       is_signed;
    logic [1:0] op_size;
    logic       done;                         // access completes this cycle
    logic [1:0] offset_q;                     // load alignment for the return cycle
    logic [1:0] size_q;
    logic       sign_q;

    assign is_store  = op[OP_STORE_BIT];
    assign is_signed = op[OP_SIGN_BIT];
    assign op_size   = op[1:0];
    assign done      = en & ~bus_wait;

    store_align u_store_align (
        .write_data (d_writedata),
        .offset     (d_address[1:0]),
        .size       (op_size),
        .byteen     (bus_byteen),
        .wdata_out  (bus_writedata)
    );

    // read data arrives one cycle after completion, so align with the latched fields
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            offset_q <= 2'b00;
            size_q   <= SIZE_WORD;
            sign_q   <= 1'b0;
        end
        else if (done)                        // held while stalled
        begin
            offset_q <= d_address[1:0];
            size_q   <= op_size;
            sign_q   <= is_signed;
        end
    end

    load_align u_load_align (
        .rdata       (bus_readdata),
        .offset      (offset_q),
        .size        (size_q),
        .sign_ext    (sign_q),
        .load_result (d_loadresult)
    );

    assign bus_address = d_address;
    assign bus_we      = is_store;
    assign bus_en      = en;
    assign stalled     = bus_wait;            // only back-pressure to the cpu
    assign ecause      = bus_ecause;

    a_legal_op: assert property (@(posedge clk) disable iff (!resetn)
        en |-> op inside {OP_LW, OP_LHU, OP_LBU, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB})
        else $error("data_mem: illegal op %0d", op);

endmodule

`default_nettype wire

// ==== hw/dmem_ram.sv ====
// byte-enabled data ram with registered read and a word-wide boot write port
`timescale 1ns/1ps
`default_nettype none

module dmem_ram
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              en,             // port a from the processor side
    input  logic              we,
    input  logic [BYTE_W-1:0] byteen,
    input  logic [RAM_AW-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata,
    input  logic [RAM_AW-1:0] boot_addr,      // port b writes whole words only
    input  logic [DATA_W-1:0] boot_data,
    input  logic              boot_we
);

    logic [DATA_W-1:0] mem [RAM_WORDS];

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (we)
            begin
                for (int i = 0; i < BYTE_W; i++)
                begin
                    if (byteen[i])            // lane 3 is bits 31:24
                        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
            rdata <= mem[addr];               // read-before-write
        end
        if (boot_we)
            mem[boot_addr] <= boot_data;
    end

    a_no_port_clash: assert property (@(posedge clk)
        !(en && we && boot_we && (addr == boot_addr)))
        else $error("dmem_ram: both ports write word %0h", addr);

endmodule

`default_nettype wire

// ==== hw/dmem_bus_fabric.sv ====
// region decode, routing to ram or io block, read data and cause return
`timescale 1ns/1ps
`default_nettype none

module dmem_bus_fabric
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic [31:0]       bus_address,
    input  logic [BYTE_W-1:0] bus_byteen,
    input  logic              bus_we,
    input  logic              bus_en,
    input  logic [DATA_W-1:0] bus_writedata,
    output logic [DATA_W-1:0] bus_readdata,
    output logic              bus_wait,
    output exc_cause_e        bus_ecause,
    output logic              ram_en,
    output logic              ram_we,
    output logic [BYTE_W-1:0] ram_byteen,
    output logic [RAM_AW-1:0] ram_addr,
    output logic [DATA_W-1:0] ram_wdata,
    input  logic [DATA_W-1:0] ram_rdata,
    output logic              io_en,
    output logic              io_we,
    output logic [BYTE_W-1:0] io_byteen,
    output logic [31:0]       io_addr,
    output logic [DATA_W-1:0] io_wdata,
    input  logic [DATA_W-1:0] io_rdata,
    input  logic              io_wait,
    input  logic              io_error
);

    logic io_sel;                             // address in the io region
    logic done;
    logic io_sel_q;                           // source of the returning read data
    logic err_q;

    assign io_sel = bus_address[REGION_BIT];
    assign done   = bus_en & ~bus_wait;

    assign ram_en     = bus_en & ~io_sel;
    assign ram_we     = bus_we;
    assign ram_byteen = bus_byteen;
    assign ram_addr   = bus_address[RAM_AW+1:2];   // byte to word address
    assign ram_wdata  = bus_writedata;

    assign io_en     = bus_en & io_sel;
    assign io_we     = bus_we;
    assign io_byteen = bus_byteen;
    assign io_addr   = bus_address;
    assign io_wdata  = bus_writedata;

    assign bus_wait = io_wait;                // ram never waits

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            io_sel_q <= 1'b0;
            err_q    <= 1'b0;
        end
        else if (done)
        begin
            io_sel_q <= io_sel;
            err_q    <= io_en & io_error;     // next edge clears it again
        end
        else
            err_q <= 1'b0;
    end

    assign bus_readdata = io_sel_q ? io_rdata : ram_rdata;
    assign bus_ecause   = err_q ? EXC_DBE : EXC_NONE;

    // a waiting access repeats unchanged until it completes
    a_hold_on_wait: assert property (@(posedge clk) disable iff (!resetn)
        bus_en && bus_wait |=> bus_en && $stable(bus_address) && $stable(bus_we)
            && $stable(bus_byteen) && $stable(bus_writedata))
        else $error("dmem_bus_fabric: access changed while waiting");

endmodule

`default_nettype wire

// ==== hw/io_regs.sv ====
// io scratch registers with byte enables, one wait cycle and unmapped flag
`timescale 1ns/1ps
`default_nettype none

module io_regs
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              en,
    input  logic              we,
    input  logic [BYTE_W-1:0] byteen,
    input  logic [31:0]       addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata,          // valid the cycle after completion
    output logic              wait_req,
    output logic              error           // unmapped address this cycle
);

    localparam int IDX_W = $clog2(IO_REGS);

    io_state_e         state;
    logic              mapped;
    logic [IDX_W-1:0]  idx;
    logic              done;
    logic [DATA_W-1:0] regs [IO_REGS];

    assign mapped   = (addr[31:IDX_W+2] == IO_BASE[31:IDX_W+2]);
    assign idx      = addr[IDX_W+1:2];
    assign wait_req = en & (state == IO_IDLE);     // first cycle always waits
    assign done     = en & (state == IO_WAIT);
    assign error    = en & ~mapped;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= IO_IDLE;
        else if (wait_req)
            state <= IO_WAIT;
        else if (done)
            state <= IO_IDLE;                     // next access waits again
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int r = 0; r < IO_REGS; r++)
                regs[r] <= '0;
        end
        else if (done && we && mapped)            // unmapped stores dropped
        begin
            for (int i = 0; i < BYTE_W; i++)
            begin
                if (byteen[i])
                    regs[idx][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (done)
            rdata <= mapped ? regs[idx] : '0;     // unmapped loads return zero
    end

endmodule

`default_nettype wire

// ==== hw/dmem_subsys.sv ====
// data memory subsystem top with interface, fabric, ram and io block
`timescale 1ns/1ps
`default_nettype none

module dmem_subsys
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              en,
    input  mem_op_e           op,
    input  logic [31:0]       d_address,
    input  logic [DATA_W-1:0] d_writedata,
    output logic [DATA_W-1:0] d_loadresult,
    output logic              stalled,
    output exc_cause_e        ecause,
    input  logic [RAM_AW-1:0] boot_daddr,     // word address
    input  logic [DATA_W-1:0] boot_ddata,
    input  logic              boot_dwe
);

    // internal bus
    logic [31:0]       bus_address;
    logic [BYTE_W-1:0] bus_byteen;
    logic              bus_we;
    logic              bus_en;
    logic [DATA_W-1:0] bus_writedata;
    logic [DATA_W-1:0] bus_readdata;
    logic              bus_wait;
    exc_cause_e        bus_ecause;

    // ram side
    logic              ram_en;
    logic              ram_we;
    logic [BYTE_W-1:0] ram_byteen;
    logic [RAM_AW-1:0] ram_addr;
    logic [DATA_W-1:0] ram_wdata;
    logic [DATA_W-1:0] ram_rdata;

    // io side
    logic              io_en;
    logic              io_we;
    logic [BYTE_W-1:0] io_byteen;
    logic [31:0]       io_addr;
    logic [DATA_W-1:0] io_wdata;
    logic [DATA_W-1:0] io_rdata;
    logic              io_wait;
    logic              io_error;

    data_mem u_data_mem (
        .clk, .resetn, .en, .op, .d_address, .d_writedata,
        .d_loadresult, .stalled, .ecause,
        .bus_address, .bus_byteen, .bus_we, .bus_en, .bus_writedata,
        .bus_readdata, .bus_wait, .bus_ecause
    );

    dmem_bus_fabric u_fabric (
        .clk, .resetn,
        .bus_address, .bus_byteen, .bus_we, .bus_en, .bus_writedata,
        .bus_readdata, .bus_wait, .bus_ecause,
        .ram_en, .ram_we, .ram_byteen, .ram_addr, .ram_wdata, .ram_rdata,
        .io_en, .io_we, .io_byteen, .io_addr, .io_wdata,
        .io_rdata, .io_wait, .io_error
    );

    dmem_ram u_ram (
        .clk,
        .en        (ram_en),
        .we        (ram_we),
        .byteen    (ram_byteen),
        .addr      (ram_addr),
        .wdata     (ram_wdata),
        .rdata     (ram_rdata),
        .boot_addr (boot_daddr),
        .boot_data (boot_ddata),
        .boot_we   (boot_dwe)
    );

    io_regs u_io_regs (
        .clk, .resetn,
        .en       (io_en),
        .we       (io_we),
        .byteen   (io_byteen),
        .addr     (io_addr),
        .wdata    (io_wdata),
        .rdata    (io_rdata),
        .wait_req (io_wait),
        .error    (io_error)
    );

endmodule

`default_nettype wire

// ==== tb/dmem_tb.sv ====
// testbench for dmem_subsys with reference model, stimulus table, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module dmem_tb
    import dmem_pkg::*;
();

    logic              clk;
    logic              resetn;
    logic              en;
    mem_op_e           op;
    logic [31:0]       d_address;
    logic [DATA_W-1:0] d_writedata;
    logic [DATA_W-1:0] d_loadresult;
    logic              stalled;
    exc_cause_e        ecause;
    logic [RAM_AW-1:0] boot_daddr;
    logic [DATA_W-1:0] boot_ddata;
    logic              boot_dwe;

    // stimulus table with one entry per processor access
    string       tab_name[$];
    mem_op_e     tab_op[$];
    logic [31:0] tab_addr[$];
    logic [31:0] tab_data[$];
    logic [31:0] tab_exp[$];
    logic        tab_check[$];                      // load result compared
    exc_cause_e  tab_cause[$];

    logic [31:0] ram_model [int];                   // only the words the tests touch
    logic [31:0] io_model [IO_REGS];
    int          boot_word[$];
    logic [31:0] boot_val[$];
    int unsigned lcg_state = 72817;
    int          errors;
    int          checks;
    logic        table_ready;

    dmem_subsys dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic io_unmapped(logic [31:0] addr);
        return addr[31] && (addr[30:4] != 0);       // io region outside the four registers
    endfunction

    function automatic logic [31:0] model_word(logic [31:0] addr);
        if (!addr[31])
            return ram_model[int'(addr[13:2])];
        if (io_unmapped(addr))
            return 32'h0;
        return io_model[addr[3:2]];
    endfunction

    // byte at offset 0 is bits 31:24 and halfword at offset 0 is bits 31:16
    function automatic logic [31:0] model_load(mem_op_e o, logic [31:0] addr);
        logic [31:0] w;
        logic [31:0] item;
        int          off;
        int          bits;
        w   = model_word(addr);
        off = int'(addr[1:0]);
        case (o)
            OP_LB, OP_LBU:
            begin
                item = (w >> (8 * (3 - off))) & 32'hFF;
                bits = 8;
            end
            OP_LH, OP_LHU:
            begin
                item = (w >> ((off >= 2) ? 0 : 16)) & 32'hFFFF;
                bits = 16;
            end
            default:
                return w;
        endcase
        if ((o == OP_LB || o == OP_LH) && item[bits-1])
            item = item | (32'hFFFF_FFFF << bits);  // sign fill
        return item;
    endfunction

    function automatic void model_store(mem_op_e o, logic [31:0] addr, logic [31:0] data);
        logic [31:0] w;
        logic [31:0] mask;
        int          sh;
        int          off;
        off = int'(addr[1:0]);
        w   = model_word(addr);
        case (o)
            OP_SB:   sh = 8 * (3 - off);
            OP_SH:   sh = (off >= 2) ? 0 : 16;
            default: sh = 0;
        endcase
        mask = (o == OP_SB) ? (32'hFF << sh) : (o == OP_SH) ? (32'hFFFF << sh) : 32'hFFFF_FFFF;
        w = (w & ~mask) | ((data << sh) & mask);    // other lanes keep old bytes
        if (!addr[31])
            ram_model[int'(addr[13:2])] = w;
        else if (!io_unmapped(addr))
            io_model[addr[3:2]] = w;                // unmapped stores dropped
    endfunction

    function automatic void add_entry(string group, mem_op_e o, logic [31:0] addr,
                                      logic [31:0] data);
        tab_name.push_back($sformatf("%s %s %08h", group, o.name(), addr));
        tab_op.push_back(o);
        tab_addr.push_back(addr);
        tab_data.push_back(data);
        tab_cause.push_back(io_unmapped(addr) ? EXC_DBE : EXC_NONE);
        tab_check.push_back(!o[OP_STORE_BIT]);
        tab_exp.push_back(o[OP_STORE_BIT] ? 32'h0 : model_load(o, addr));
        if (o[OP_STORE_BIT])
            model_store(o, addr, data);
    endfunction

    function automatic void add_boot(int word, logic [31:0] data);
        boot_word.push_back(word);
        boot_val.push_back(data);
        ram_model[word] = data;
    endfunction

    function automatic void build_table();
        int words[6] = '{0, 1, 2, 5, 6, RAM_WORDS - 1};
        for (int r = 0; r < IO_REGS; r++)
            io_model[r] = 32'h0;                    // io registers clear after reset
        for (int k = 0; k < 6; k++)
            add_boot(words[k], next_rand());
        add_boot(3, 32'h807F_F00F);                 // bytes with top bit set and clear
        add_boot(4, 32'h7F80_0FF0);                 // both halves with top bit clear
        for (int k = 0; k < boot_word.size(); k++)
            add_entry("boot", OP_LW, 32'(boot_word[k] * 4), 32'h0);
        for (int off = 0; off < 4; off++)
        begin
            add_entry("sb", OP_SB, 32'h4 + off, next_rand());
            add_entry("sb", OP_LW, 32'h4, 32'h0);
        end
        for (int off = 0; off < 4; off += 2)
        begin
            add_entry("sh", OP_SH, 32'h8 + off, next_rand());
            add_entry("sh", OP_LW, 32'h8, 32'h0);
        end
        add_entry("sw", OP_SW, 32'h14, next_rand());
        add_entry("sw", OP_LW, 32'h14, 32'h0);
        for (int off = 0; off < 4; off++)
        begin
            add_entry("ext", OP_LB, 32'hC + off, 32'h0);
            add_entry("ext", OP_LBU, 32'hC + off, 32'h0);
        end
        for (int off = 0; off < 4; off += 2)
        begin
            add_entry("ext", OP_LH, 32'hC + off, 32'h0);
            add_entry("ext", OP_LHU, 32'hC + off, 32'h0);
            add_entry("ext", OP_LH, 32'h10 + off, 32'h0);
            add_entry("ext", OP_LHU, 32'h10 + off, 32'h0);
        end
        for (int r = 0; r < IO_REGS; r++)
            add_entry("io", OP_SW, IO_BASE + 4 * r, next_rand());
        for (int r = 0; r < IO_REGS; r++)
            add_entry("io", OP_LW, IO_BASE + 4 * r, 32'h0);
        add_entry("io", OP_SB, IO_BASE + 32'h5, next_rand());
        add_entry("io", OP_LW, IO_BASE + 32'h4, 32'h0);
        add_entry("io", OP_SH, IO_BASE + 32'h8, next_rand());
        add_entry("io", OP_LH, IO_BASE + 32'h8, 32'h0);
        add_entry("io", OP_LB, IO_BASE + 32'hF, 32'h0);
        add_entry("io", OP_LHU, IO_BASE + 32'hE, 32'h0);
        add_entry("unmapped", OP_SW, IO_BASE + 32'h40, next_rand());
        add_entry("unmapped", OP_LW, IO_BASE + 32'h40, 32'h0);
        add_entry("unmapped", OP_SB, IO_BASE + 32'h13, next_rand());
        add_entry("unmapped", OP_LB, IO_BASE + 32'h13, 32'h0);
        for (int r = 0; r < IO_REGS; r++)
            add_entry("unmapped", OP_LW, IO_BASE + 4 * r, 32'h0);   // registers untouched
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input exc_cause_e exp, input exc_cause_e act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s cause: expected %0d (%s) actual %0d (%s)",
                     name, exp, exp.name(), act, act.name());
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s stalled: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic boot_write(input int word, input logic [31:0] data);
        boot_daddr = RAM_AW'(word);
        boot_ddata = data;
        boot_dwe   = 1'b1;
        @(posedge clk);                             // word written at this edge
        #1 boot_dwe = 1'b0;
    endtask

    // called 1 ns after a rising edge and returns in the result cycle
    task automatic apply_entry(input int i);
        logic [31:0] addr;
        logic        io;
        addr        = tab_addr[i];
        io          = addr[REGION_BIT];
        en          = 1'b1;
        op          = tab_op[i];
        d_address   = addr;
        d_writedata = tab_data[i];
        @(negedge clk);
        check_cause({tab_name[i], " idle"}, EXC_NONE, ecause);     // earlier cause gone
        check_stall(tab_name[i], io, stalled);      // io waits once and ram never
        while (stalled)
        begin
            @(negedge clk);                         // inputs held through the stall
            check_stall(tab_name[i], 1'b0, stalled);
        end
        @(posedge clk);                             // completing edge
        #1 en = 1'b0;
        @(negedge clk);
        if (tab_check[i])
            check_word(tab_name[i], tab_exp[i], d_loadresult);
        check_cause(tab_name[i], tab_cause[i], ecause);
    endtask

    initial
    begin
        int limit;
        wait (table_ready);
        limit = tab_name.size() * 4 + 64;           // reset and boot writes fit in the margin
        repeat (limit) @(posedge clk);
        $display("timeout: run hung, no end after %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        resetn      = 1'b0;
        en          = 1'b0;
        op          = OP_LW;
        d_address   = 32'h0;
        d_writedata = 32'h0;
        boot_daddr  = '0;
        boot_ddata  = 32'h0;
        boot_dwe    = 1'b0;
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check_stall("after reset", 1'b0, stalled);
        check_cause("after reset", EXC_NONE, ecause);
        @(posedge clk);
        #1;
        for (int b = 0; b < boot_word.size(); b++)
            boot_write(boot_word[b], boot_val[b]);
        for (int i = 0; i < tab_name.size(); i++)
        begin
            apply_entry(i);
            @(posedge clk);
            #1;
        end
        @(negedge clk);
        check_cause("final idle", EXC_NONE, ecause);   // bus error lasts one cycle only
        $display("%0d errors in %0d checks over %0d accesses", errors, checks, tab_name.size());
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dmem_subsys.f ====
hw/dmem_pkg.sv
hw/store_align.sv
hw/load_align.sv
hw/data_mem.sv
hw/dmem_ram.sv
hw/dmem_bus_fabric.sv
hw/io_regs.sv
hw/dmem_subsys.sv
tb/dmem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dmem_subsys testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dmem_tb_sim

verilator --binary --timing --assert -f dmem_subsys.f \
    --top-module dmem_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, see $LOG"
    exit 1
fi
